// ==== arith16_top.f ====
hdl/alu_pkg.sv
hdl/fp16_pkg.sv
hdl/op_if.sv
hdl/res_if.sv
hdl/operand_stage.sv
hdl/fixed_mult.sv
hdl/fp_add.sv
hdl/arith_core.sv
hdl/result_stage.sv
hdl/arith16_top.sv
test/arith16_tb.sv

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

    // operation codes seen on the op port.
    typedef enum logic [1:0]
    {
        OP_INT_ADD = 2'd0, // wrapping add, carry out reported as overflow.
        OP_FIX_MUL = 2'd1, // unsigned q8.8 multiply.
        OP_FP_ADD  = 2'd2  // binary16 add.
    } op_e;

    // operand and result width.
    localparam int DATA_W = 16;

    // in_valid sample to out_valid, one register per stage.
    localparam int PIPE_LATENCY = 3;

endpackage

// ==== hdl/arith16_top.sv ====
`timescale 1ns/1ps

module arith16_top
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  alu_pkg::op_e               op,
    input  logic [alu_pkg::DATA_W-1:0] num1,
    input  logic [alu_pkg::DATA_W-1:0] num2,
    output logic                       out_valid,
    output logic [alu_pkg::DATA_W-1:0] result,
    output logic                       overflow,
    output logic                       zero,
    output logic                       nan,
    output logic                       precision_lost
);

    op_if  u_op_if ();
    res_if u_res_if ();

    operand_stage u_operand_stage
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .num1     (num1),
        .num2     (num2),
        .opd      (u_op_if.src)
    );

    arith_core u_arith_core
    (
        .clk   (clk),
        .rst_n (rst_n),
        .opd   (u_op_if.dst),
        .res   (u_res_if.src)
    );

    result_stage u_result_stage
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .res            (u_res_if.dst),
        .out_valid      (out_valid),
        .result         (result),
        .overflow       (overflow),
        .zero           (zero),
        .nan            (nan),
        .precision_lost (precision_lost)
    );

endmodule

// ==== hdl/arith_core.sv ====
`timescale 1ns/1ps

module arith_core
(
    input logic clk,
    input logic rst_n,
    op_if.dst   opd,
    res_if.src  res
);

    logic [alu_pkg::DATA_W:0]   int_sum;
    logic [alu_pkg::DATA_W-1:0] mul_result;
    logic                       mul_overflow;
    logic                       mul_precision_lost;
    logic [alu_pkg::DATA_W-1:0] fp_result;
    logic                       fp_overflow;
    logic                       fp_zero;
    logic                       fp_nan;
    logic                       fp_precision_lost;
    logic [alu_pkg::DATA_W-1:0] sel_result;
    logic                       sel_overflow;
    logic                       sel_precision_lost;

    assign int_sum = {1'b0, opd.a} + {1'b0, opd.b};

    fixed_mult u_fixed_mult
    (
        .a              (opd.a),
        .b              (opd.b),
        .result         (mul_result),
        .overflow       (mul_overflow),
        .precision_lost (mul_precision_lost)
    );

    fp_add u_fp_add
    (
        .big_num        (opd.big_num),
        .small_num      (opd.small_num),
        .a              (opd.a),
        .b              (opd.b),
        .result         (fp_result),
        .overflow       (fp_overflow),
        .zero           (fp_zero),
        .nan            (fp_nan),
        .precision_lost (fp_precision_lost)
    );

    always_comb
    begin
        case (opd.op)
            alu_pkg::OP_INT_ADD:
            begin
                sel_result   = int_sum[alu_pkg::DATA_W-1:0];
                sel_overflow = int_sum[alu_pkg::DATA_W];
            end
            alu_pkg::OP_FIX_MUL:
            begin
                sel_result   = mul_result;
                sel_overflow = mul_overflow;
            end
            default:
            begin
                sel_result   = fp_result;
                sel_overflow = fp_overflow;
            end
        endcase
    end

    // the integer add has no such flag, it is masked on output.
    assign sel_precision_lost = (opd.op == alu_pkg::OP_FP_ADD) ? fp_precision_lost
                                                               : mul_precision_lost;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            res.valid <= 1'b0;
        else
            res.valid <= opd.valid;
    end

    always_ff @(posedge clk)
    begin
        if (opd.valid)
        begin
            res.op             <= opd.op;
            res.result         <= sel_result;
            res.overflow       <= sel_overflow;
            res.zero           <= fp_zero;
            res.nan            <= fp_nan;
            res.precision_lost <= sel_precision_lost;
        end
    end

endmodule

// ==== hdl/fixed_mult.sv ====
`timescale 1ns/1ps

module fixed_mult
(
    input  logic [alu_pkg::DATA_W-1:0] a,
    input  logic [alu_pkg::DATA_W-1:0] b,
    output logic [alu_pkg::DATA_W-1:0] result,
    output logic                       overflow,
    output logic                       precision_lost
);

    logic [fp16_pkg::FIX_PROD_W-1:0] a_ext;
    logic [fp16_pkg::FIX_PROD_W-1:0] partial [alu_pkg::DATA_W];
    logic [fp16_pkg::FIX_PROD_W-1:0] product;

    assign a_ext = {{(fp16_pkg::FIX_PROD_W - alu_pkg::DATA_W){1'b0}}, a};

    // one shifted copy of a per set bit of b.
    always_comb
    begin
        for (int i = 0; i < alu_pkg::DATA_W; i++)
        begin
            partial[i] = (a_ext << i) & {fp16_pkg::FIX_PROD_W{b[i]}};
        end
    end

    always_comb
    begin
        product = '0;
        for (int i = 0; i < alu_pkg::DATA_W; i++)
        begin
            product = product + partial[i];
        end
    end

    // q16.16 product back to q8.8.
    assign result         = product[fp16_pkg::FIX_FRAC_W +: alu_pkg::DATA_W];
    assign overflow       = |product[fp16_pkg::FIX_PROD_W-1:fp16_pkg::FIX_FRAC_W+alu_pkg::DATA_W];
    assign precision_lost = |product[fp16_pkg::FIX_FRAC_W-1:0]; // truncated, never rounded.

endmodule

// ==== hdl/fp16_pkg.sv ====
package fp16_pkg;

    // binary16 field layout.
    localparam int EXP_W        = 5;
    localparam int FRAC_W       = 10;
    localparam int SIG_W        = FRAC_W + 1; // hidden bit included.

    // exponent codes with a special meaning.
    localparam int EXP_MAX      = 31;         // infinity and nan.
    localparam int EXP_OVF_EDGE = 30;         // a carry here runs out of range.

    // q8.8 fixed point.
    localparam int FIX_FRAC_W   = 8;
    localparam int FIX_PROD_W   = 32;

endpackage

// ==== hdl/fp_add.sv ====
`timescale 1ns/1ps

module fp_add
(
    input  logic [alu_pkg::DATA_W-1:0] big_num,
    input  logic [alu_pkg::DATA_W-1:0] small_num,
    input  logic [alu_pkg::DATA_W-1:0] a,
    input  logic [alu_pkg::DATA_W-1:0] b,
    output logic [alu_pkg::DATA_W-1:0] result,
    output logic                       overflow,
    output logic                       zero,
    output logic                       nan,
    output logic                       precision_lost
);

    logic                                                      big_sign;
    logic                                                      small_sign;
    logic [fp16_pkg::EXP_W-1:0]                                big_exp_raw;
    logic [fp16_pkg::EXP_W-1:0]                                small_exp_raw;
    logic [fp16_pkg::FRAC_W-1:0]                               big_frac;
    logic [fp16_pkg::FRAC_W-1:0]                               small_frac;
    logic [fp16_pkg::EXP_W-1:0]                                big_exp;
    logic [fp16_pkg::EXP_W-1:0]                                small_exp;
    logic [fp16_pkg::EXP_W-1:0]                                exp_diff;
    logic [fp16_pkg::SIG_W-1:0]                                big_sig;
    logic [fp16_pkg::SIG_W-1:0]                                small_sig;
    logic [fp16_pkg::SIG_W+fp16_pkg::FRAC_W+2**fp16_pkg::EXP_W-1:0] small_shift;
    logic [fp16_pkg::SIG_W+fp16_pkg::FRAC_W-1:0]               big_wide;
    logic [fp16_pkg::SIG_W+fp16_pkg::FRAC_W-1:0]               small_wide;
    logic [fp16_pkg::SIG_W+fp16_pkg::FRAC_W:0]                 addend;
    logic [fp16_pkg::SIG_W+fp16_pkg::FRAC_W:0]                 sum_wide;
    logic                                                      far_lost;
    logic                                                      same_sign;
    logic                                                      carry;
    logic                                                      inf_in;
    logic [fp16_pkg::EXP_W-1:0]                                lzc;
    logic [fp16_pkg::EXP_W-1:0]                                shift_amt;
    logic [fp16_pkg::SIG_W+fp16_pkg::FRAC_W-1:0]               norm;
    logic [fp16_pkg::EXP_W-1:0]                                norm_exp;

    assign {big_sign, big_exp_raw, big_frac}       = big_num;
    assign {small_sign, small_exp_raw, small_frac} = small_num;
    assign same_sign = (big_sign == small_sign);

    // subnormals sit at exponent 1 without the hidden bit.
    assign big_exp   = big_exp_raw + {{(fp16_pkg::EXP_W-1){1'b0}}, ~|big_exp_raw};
    assign small_exp = small_exp_raw + {{(fp16_pkg::EXP_W-1){1'b0}}, ~|small_exp_raw};
    assign big_sig   = {|big_exp_raw, big_frac};
    assign small_sig = {|small_exp_raw, small_frac};
    assign exp_diff  = big_exp - small_exp;

    // aligned significand, extension below it, then bits that fall off entirely.
    assign small_shift = {small_sig, {(fp16_pkg::FRAC_W + 2**fp16_pkg::EXP_W){1'b0}}} >> exp_diff;
    assign small_wide  = small_shift[$high(small_shift) -: fp16_pkg::SIG_W + fp16_pkg::FRAC_W];
    assign far_lost    = |small_shift[2**fp16_pkg::EXP_W-1:0];
    assign big_wide    = {big_sig, {fp16_pkg::FRAC_W{1'b0}}};

    assign addend   = same_sign ? {1'b0, small_wide} : ~{1'b0, small_wide} + 1'b1;
    assign sum_wide = {1'b0, big_wide} + addend;
    assign carry    = same_sign & sum_wide[fp16_pkg::SIG_W+fp16_pkg::FRAC_W];

    always_comb
    begin
        lzc = fp16_pkg::EXP_W'(fp16_pkg::SIG_W + fp16_pkg::FRAC_W);
        for (int i = 0; i < fp16_pkg::SIG_W + fp16_pkg::FRAC_W; i++)
        begin
            if (sum_wide[i])
            begin
                lzc = fp16_pkg::EXP_W'(fp16_pkg::SIG_W + fp16_pkg::FRAC_W - 1 - i);
            end
        end
    end

    // never shift below exponent 1, the rest stays subnormal.
    assign shift_amt = (lzc < big_exp) ? lzc : big_exp - 1'b1;
    assign norm      = sum_wide[fp16_pkg::SIG_W+fp16_pkg::FRAC_W-1:0] << shift_amt;
    assign norm_exp  = norm[fp16_pkg::SIG_W+fp16_pkg::FRAC_W-1] ? big_exp - shift_amt : '0;

    assign nan    = ((big_exp_raw == fp16_pkg::EXP_MAX) && (|big_frac))
                 || ((small_exp_raw == fp16_pkg::EXP_MAX) && (|small_frac));
    assign inf_in = ((big_exp_raw == fp16_pkg::EXP_MAX) && !(|big_frac))
                 || ((small_exp_raw == fp16_pkg::EXP_MAX) && !(|small_frac));
    assign overflow = inf_in || (carry && (big_exp == fp16_pkg::EXP_OVF_EDGE));
    assign zero     = (a[alu_pkg::DATA_W-2:0] == b[alu_pkg::DATA_W-2:0])
                   && (a[alu_pkg::DATA_W-1] != b[alu_pkg::DATA_W-1]);

    always_comb
    begin
        if (nan)
        begin
            result = {1'b0, {fp16_pkg::EXP_W{1'b1}}, 1'b1, {(fp16_pkg::FRAC_W-1){1'b0}}};
        end
        else if (overflow)
        begin
            result = {big_sign, {fp16_pkg::EXP_W{1'b1}}, {fp16_pkg::FRAC_W{1'b0}}};
        end
        else if (carry)
        begin
            result = {big_sign, big_exp + 1'b1,
                      sum_wide[fp16_pkg::SIG_W+fp16_pkg::FRAC_W-1 -: fp16_pkg::FRAC_W]};
        end
        else
        begin
            result = {big_sign, norm_exp,
                      norm[fp16_pkg::SIG_W+fp16_pkg::FRAC_W-2 -: fp16_pkg::FRAC_W]};
        end
    end

    always_comb
    begin
        if (nan || overflow)
            precision_lost = 1'b0;
        else if (carry)
            precision_lost = (|sum_wide[fp16_pkg::FRAC_W:0]) | far_lost; // lsb shifted out too.
        else
            precision_lost = (|norm[fp16_pkg::FRAC_W-1:0]) | far_lost;
    end

endmodule

// ==== hdl/op_if.sv ====
`timescale 1ns/1ps

interface op_if;

    logic                       valid;
    alu_pkg::op_e               op;
    logic [alu_pkg::DATA_W-1:0] a;
    logic [alu_pkg::DATA_W-1:0] b;
    logic [alu_pkg::DATA_W-1:0] big_num;   // larger binary16 magnitude.
    logic [alu_pkg::DATA_W-1:0] small_num;

    modport src
    (
        output valid,
        output op,
        output a,
        output b,
        output big_num,
        output small_num
    );

    modport dst
    (
        input valid,
        input op,
        input a,
        input b,
        input big_num,
        input small_num
    );

endinterface

// ==== hdl/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  alu_pkg::op_e               op,
    input  logic [alu_pkg::DATA_W-1:0] num1,
    input  logic [alu_pkg::DATA_W-1:0] num2,
    op_if.src                          opd
);

    logic [fp16_pkg::EXP_W-1:0]  exp1;
    logic [fp16_pkg::EXP_W-1:0]  exp2;
    logic [fp16_pkg::FRAC_W-1:0] frac1;
    logic [fp16_pkg::FRAC_W-1:0] frac2;
    logic                        swap;

    assign exp1  = num1[fp16_pkg::FRAC_W +: fp16_pkg::EXP_W];
    assign exp2  = num2[fp16_pkg::FRAC_W +: fp16_pkg::EXP_W];
    assign frac1 = num1[fp16_pkg::FRAC_W-1:0];
    assign frac2 = num2[fp16_pkg::FRAC_W-1:0];

    // num2 leads only when strictly larger, ties keep num1 in front.
    assign swap = (exp2 > exp1) || ((exp2 == exp1) && (frac2 > frac1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            opd.valid <= 1'b0;
        end
        else
        begin
            opd.valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            opd.op        <= op;
            opd.a         <= num1;
            opd.b         <= num2;
            opd.big_num   <= swap ? num2 : num1;
            opd.small_num <= swap ? num1 : num2; // only the adder looks at these.
        end
    end

    a_op_known : assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> !$isunknown(op))
        else $error("op is unknown while in_valid is high");

endmodule

// ==== hdl/res_if.sv ====
`timescale 1ns/1ps

interface res_if;

    logic                       valid;
    alu_pkg::op_e               op;
    logic [alu_pkg::DATA_W-1:0] result;
    logic                       overflow;
    logic                       zero;
    logic                       nan;
    logic                       precision_lost;

    modport src
    (
        output valid,
        output op,
        output result,
        output overflow,
        output zero,
        output nan,
        output precision_lost
    );

    modport dst
    (
        input valid,
        input op,
        input result,
        input overflow,
        input zero,
        input nan,
        input precision_lost
    );

endinterface

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps

module result_stage
(
    input  logic                       clk,
    input  logic                       rst_n,
    res_if.dst                         res,
    output logic                       out_valid,
    output logic [alu_pkg::DATA_W-1:0] result,
    output logic                       overflow,
    output logic                       zero,
    output logic                       nan,
    output logic                       precision_lost
);

    logic is_fp;

    assign is_fp = (res.op == alu_pkg::OP_FP_ADD);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid      <= 1'b0;
            overflow       <= 1'b0;
            zero           <= 1'b0;
            nan            <= 1'b0;
            precision_lost <= 1'b0;
        end
        else
        begin
            out_valid <= res.valid; // one-cycle pulse per item.
            if (res.valid)
            begin
                overflow       <= res.overflow;
                zero           <= res.zero & is_fp;
                nan            <= res.nan & is_fp;
                precision_lost <= res.precision_lost & (res.op != alu_pkg::OP_INT_ADD);
            end
        end
    end

    // held until the next item arrives.
    always_ff @(posedge clk)
    begin
        if (res.valid)
            result <= res.result;
    end

    a_b2b_src : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && $past(out_valid) |-> $past(res.valid) && $past(res.valid, 2))
        else $error("back-to-back out_valid without two upstream items");

endmodule

// ==== test/arith16_tb.sv ====
`timescale 1ns/1ps

module arith16_tb;

    localparam int          RESET_CYCLES   = 10;
    localparam int          TIMEOUT_MARGIN = 50;
    localparam int          N_INT          = 40;
    localparam int          N_MUL          = 40;
    localparam int          N_FP_PAIRS     = 30;
    localparam int          N_ZERO         = 3;
    localparam int          N_B2B          = 24;
    localparam logic [31:0] SEED           = 32'h228a_1a0e;
    localparam logic [19:0] CARE_ALL       = 20'hfffff;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    alu_pkg::op_e         op;
    logic [15:0]          num1;
    logic [15:0]          num2;
    logic                 out_valid;
    logic [15:0]          result;
    logic                 overflow;
    logic                 zero;
    logic                 nan;
    logic                 precision_lost;

    // entry is {care mask, expected}, each {result, overflow, zero, nan, precision_lost}.
    logic [39:0]          exp_q [$];
    logic [19:0]          exp_head;
    logic [19:0]          care_head;
    int                   pending;
    int                   issued;
    int                   done;
    int                   cycles;

    arith16_top DUT
    (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .op             (op),
        .num1           (num1),
        .num2           (num2),
        .out_valid      (out_valid),
        .result         (result),
        .overflow       (overflow),
        .zero           (zero),
        .nan            (nan),
        .precision_lost (precision_lost)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [15:0] expv,
                                input logic [15:0] got);
        abort_run($sformatf("ERR %s expected 0x%h got 0x%h", name, expv, got));
    endtask

    task automatic refresh_head();
        pending = exp_q.size();
        {care_head, exp_head} = (pending != 0) ? exp_q[0] : 40'd0;
    endtask

    // exact only while v fits in 11 significant bits.
    function automatic logic [15:0] int_to_half(input int unsigned v);
        int p;
        p = 0;
        for (int i = 0; i < 16; i++)
        begin
            if (v[i])
                p = i;
        end
        return {1'b0, 5'(15 + p), 10'((v << 10) >> p)};
    endfunction

    task automatic issue(input alu_pkg::op_e code, input logic [15:0] n1,
                         input logic [15:0] n2, input logic [19:0] exp_v,
                         input logic [19:0] care_v);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= code;
        num1     <= n1;
        num2     <= n2;
        exp_q.push_back({care_v, exp_v});
        issued++;
        refresh_head();
    endtask

    task automatic issue_fp_sum(input int unsigned x, input int unsigned y);
        issue(alu_pkg::OP_FP_ADD, int_to_half(x), int_to_half(y),
              {int_to_half(x + y), 4'b0000}, CARE_ALL);
    endtask

    function automatic logic [15:0] random_q88();
        if ($urandom_range(0, 1) != 0)
            return 16'($urandom);
        return 16'($urandom_range(0, 16'h0fff)); // small enough to stay in range.
    endfunction

    task automatic issue_random(input alu_pkg::op_e code);
        logic [15:0] a;
        logic [15:0] b;
        logic [16:0] sum;
        logic [31:0] prod;
        case (code)
            alu_pkg::OP_INT_ADD:
            begin
                a   = 16'($urandom);
                b   = 16'($urandom);
                sum = {1'b0, a} + {1'b0, b};
                issue(code, a, b, {sum[15:0], sum[16], 3'b000}, CARE_ALL);
            end
            alu_pkg::OP_FIX_MUL:
            begin
                a    = random_q88();
                b    = random_q88();
                prod = {16'd0, a} * {16'd0, b};
                issue(code, a, b, {prod[23:8], |prod[31:24], 2'b00, |prod[7:0]}, CARE_ALL);
            end
            default:
            begin
                issue_fp_sum($urandom_range(1, 1000), $urandom_range(1, 1000));
            end
        endcase
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    always @(posedge clk)
    begin
        if (rst_n && out_valid && exp_q.size() != 0)
        begin
            void'(exp_q.pop_front());
            done++;
            refresh_head();
        end
    end

    always @(posedge clk)
    begin
        if (rst_n)
        begin
            cycles <= cycles + 1;
            if (cycles > issued + TIMEOUT_MARGIN)
                abort_run("timeout: results did not arrive in time");
        end
    end

    a_result : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ((result ^ exp_head[19:4]) & care_head[19:4]) == 16'd0)
        else report_value("result", $sampled(exp_head[19:4]), $sampled(result));

    a_overflow : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !care_head[3] || overflow == exp_head[3])
        else report_value("overflow", $sampled(exp_head[3]), $sampled(overflow));

    a_zero : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !care_head[2] || zero == exp_head[2])
        else report_value("zero", $sampled(exp_head[2]), $sampled(zero));

    a_nan : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !care_head[1] || nan == exp_head[1])
        else report_value("nan", $sampled(exp_head[1]), $sampled(nan));

    a_precision : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !care_head[0] || precision_lost == exp_head[0])
        else report_value("precision_lost", $sampled(exp_head[0]), $sampled(precision_lost));

    a_pending : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> pending != 0)
        else abort_run("out_valid rose with no operation outstanding");

    a_latency : assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##(alu_pkg::PIPE_LATENCY) out_valid)
        else abort_run("out_valid missing the expected number of cycles after in_valid");

    a_no_early : assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, alu_pkg::PIPE_LATENCY))
        else abort_run("out_valid without a matching in_valid");

    initial
    begin
        int unsigned x;
        int unsigned y;
        logic [15:0] h;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = alu_pkg::OP_INT_ADD;
        num1     = 16'd0;
        num2     = 16'd0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < N_INT; i++)
            issue_random(alu_pkg::OP_INT_ADD);
        drain();
        for (int i = 0; i < N_MUL; i++)
            issue_random(alu_pkg::OP_FIX_MUL);
        drain();

        // both operand orders of each pair.
        for (int i = 0; i < N_FP_PAIRS; i++)
        begin
            x = $urandom_range(1, 1000);
            y = $urandom_range(1, 1000);
            issue_fp_sum(x, y);
            issue_fp_sum(y, x);
        end
        drain();

        issue(alu_pkg::OP_FP_ADD, 16'h7e00, 16'h3c00, {16'h7c00, 4'b0010}, {16'h7c00, 4'b1110});
        issue(alu_pkg::OP_FP_ADD, 16'h3c00, 16'h7d55, {16'h7c00, 4'b0010}, {16'h7c00, 4'b1110});
        issue(alu_pkg::OP_FP_ADD, 16'h7c00, 16'h3c00, {16'h7c00, 4'b1000}, {16'h7fff, 4'b1110});
        issue(alu_pkg::OP_FP_ADD, 16'h3c00, 16'hfc00, {16'h7c00, 4'b1000}, {16'h7fff, 4'b1110});
        h = int_to_half(60000);
        issue(alu_pkg::OP_FP_ADD, h, h, {16'h7c00, 4'b1000}, {16'h7fff, 4'b1110});
        for (int i = 0; i < N_ZERO; i++)
        begin
            h = int_to_half($urandom_range(1, 1000));
            issue(alu_pkg::OP_FP_ADD, h, h | 16'h8000, {16'h0000, 4'b0100}, {16'h7fff, 4'b1111});
            issue(alu_pkg::OP_FP_ADD, h | 16'h8000, h, {16'h0000, 4'b0100}, {16'h7fff, 4'b1111});
        end
        drain();

        for (int i = 0; i < N_B2B; i++)
            issue_random(alu_pkg::op_e'($urandom_range(0, 2)));
        drain();
        repeat (alu_pkg::PIPE_LATENCY) @(posedge clk);

        if (exp_q.size() == 0 && done == issued)
        begin
            $display("TESTBENCH PASSED");
            $finish;
        end
        else
        begin
            abort_run("results missing at the end of the run");
        end
    end

endmodule
